// ==== files.f ====
+incdir+hw
hw/mem_bus_pkg.sv
hw/mem_ctrl_pkg.sv
hw/mem_req_if.sv
hw/mem_client_arb.sv
hw/mem_video_port.sv
hw/mem_port_mux.sv
hw/mem_subsys.sv
tb/tb_clock.sv
tb/mem_model.sv
tb/tb_mem_subsys.sv

// ==== hw/mem_bus_pkg.sv ====
`include "mem_consts.svh"

package mem_bus_pkg;

	typedef logic [`MEM_ADDR_W-1:0] mem_addr_t; // Line address
	typedef logic [`MEM_DATA_W-1:0] mem_data_t; // Line data
	typedef logic [`MEM_DATA_W/8-1:0] mem_be_t; // One enable per byte

	// Client request opcode
	typedef enum logic {
		op_read = 1'b0,
		op_write = 1'b1
	} mem_op_e;

	typedef logic [$clog2(`MEM_CLIENTS)-1:0] client_idx_t; // Client number

endpackage

// ==== hw/mem_client_arb.sv ====
`timescale 1ns/1ns
`include "mem_consts.svh"

module mem_client_arb
	import mem_bus_pkg::*, mem_ctrl_pkg::*;
(
	input logic clkrst_mem_clk,
	input logic reset,
	input logic [`MEM_CLIENTS-1:0] cli_valid,
	input mem_op_e [`MEM_CLIENTS-1:0] cli_opcode,
	input mem_addr_t [`MEM_CLIENTS-1:0] cli_addr,
	input mem_data_t [`MEM_CLIENTS-1:0] cli_wdata,
	input mem_be_t [`MEM_CLIENTS-1:0] cli_wbe,
	output logic [`MEM_CLIENTS-1:0] cli_stall,
	output logic [`MEM_CLIENTS-1:0] cli_rvalid,
	output mem_data_t cli_rdata,
	mem_req_if.requester cpu_bus
);

	arb_state_e slot_state;
	mem_op_e slot_op;
	mem_addr_t slot_addr;
	mem_data_t slot_wdata;
	mem_be_t slot_wbe;
	client_idx_t slot_idx;
	client_idx_t last_idx; // Last winner
	client_idx_t pick_idx;
	logic pick_found;
	logic take; // Slot loads a client request
	logic slot_go; // Slot handed to the mux
	client_idx_t idx_q [`MEM_MAX_RD]; // Issuer of each read in flight
	logic [$clog2(`MEM_MAX_RD)-1:0] idx_wr, idx_rd;
	rd_count_t idx_cnt;
	logic idx_push, idx_pop;

	// Round robin, first valid client after the last winner
	always_comb begin : rr_pick
		int cand;
		pick_idx = last_idx;
		pick_found = 1'b0;
		for (int i = 1; i <= `MEM_CLIENTS; i++) begin
			cand = (int'(last_idx) + i) % `MEM_CLIENTS;
			if (!pick_found && cli_valid[cand]) begin
				pick_idx = client_idx_t'(cand);
				pick_found = 1'b1;
			end
		end
	end

	assign take = (slot_state == arb_idle) && pick_found;
	assign slot_go = cpu_bus.valid && !cpu_bus.stall;

	always_comb begin
		for (int i = 0; i < `MEM_CLIENTS; i++) begin
			cli_stall[i] = (slot_state == arb_busy) || (pick_found && pick_idx != i); // Busy or lost
			cli_rvalid[i] = cpu_bus.rvalid && (idx_q[idx_rd] == i); // Steer to issuer
		end
	end

	assign cli_rdata = cpu_bus.rdata; // Shared by all clients

	always_ff @(posedge clkrst_mem_clk) begin
		if (reset) begin
			slot_state <= arb_idle;
			last_idx <= client_idx_t'(`MEM_CLIENTS - 1); // Client 0 goes first
		end else if (take) begin
			slot_state <= arb_busy;
			last_idx <= pick_idx; // Pointer moves only on acceptance
		end else if (slot_go) begin
			slot_state <= arb_idle;
		end
	end

	always_ff @(posedge clkrst_mem_clk) begin
		if (take) begin
			slot_op <= cli_opcode[pick_idx];
			slot_addr <= cli_addr[pick_idx];
			slot_wdata <= cli_wdata[pick_idx];
			slot_wbe <= cli_wbe[pick_idx];
			slot_idx <= pick_idx;
		end
	end

	assign cpu_bus.valid = (slot_state == arb_busy);
	assign cpu_bus.opcode = slot_op;
	assign cpu_bus.addr = slot_addr;
	assign cpu_bus.wdata = slot_wdata;
	assign cpu_bus.wbe = slot_wbe;

	// Issuer queue, same order as the mux takes reads
	assign idx_push = slot_go && (slot_op == op_read);
	assign idx_pop = cpu_bus.rvalid;

	always_ff @(posedge clkrst_mem_clk) begin
		if (reset) begin
			idx_wr <= '0;
			idx_rd <= '0;
			idx_cnt <= '0;
		end else begin
			if (idx_push)
				idx_wr <= idx_wr + 1'b1;
			if (idx_pop)
				idx_rd <= idx_rd + 1'b1;
			if (idx_push && !idx_pop)
				idx_cnt <= idx_cnt + 1'b1;
			else if (idx_pop && !idx_push)
				idx_cnt <= idx_cnt - 1'b1;
		end
	end

	always_ff @(posedge clkrst_mem_clk) begin
		if (idx_push)
			idx_q[idx_wr] <= slot_idx;
	end

	a_rvalid_onehot: assert property (@(posedge clkrst_mem_clk) disable iff (reset)
		$onehot0(cli_rvalid));

	// Mux must only return reads this slot handed over
	a_rvalid_owned: assert property (@(posedge clkrst_mem_clk) disable iff (reset)
		cpu_bus.rvalid |-> idx_cnt != '0);

endmodule

// ==== hw/mem_consts.svh ====
`ifndef MEM_CONSTS_SVH
`define MEM_CONSTS_SVH

`define MEM_CLIENTS 3 // CPU-side clients
`define MEM_DATA_W 64 // Line data bits
`define MEM_ADDR_W 24 // Line address bits

// Reads in flight at the memory port
`define MEM_MAX_RD 4

`endif

// ==== hw/mem_ctrl_pkg.sv ====
`include "mem_consts.svh"

package mem_ctrl_pkg;

	// Who asked for a read at the memory port
	typedef enum logic {
		src_cpu = 1'b0,
		src_video = 1'b1
	} rd_src_e;

	typedef enum logic {
		arb_idle = 1'b0, // Slot empty
		arb_busy = 1'b1 // Slot holds a request
	} arb_state_e;

	typedef logic [$clog2(`MEM_MAX_RD):0] rd_count_t; // Counts 0 to MEM_MAX_RD

endpackage

// ==== hw/mem_port_mux.sv ====
`timescale 1ns/1ns
`include "mem_consts.svh"

module mem_port_mux
	import mem_bus_pkg::*, mem_ctrl_pkg::*;
(
	input logic clkrst_mem_clk,
	input logic reset,
	mem_req_if.responder cpu_bus,
	mem_req_if.responder video_bus,
	output logic mem_read_req,
	output logic mem_write_req,
	output mem_addr_t mem_addr,
	output mem_data_t mem_wdata,
	output mem_be_t mem_be,
	input logic mem_ready,
	input logic mem_rdata_valid,
	input mem_data_t mem_rdata
);

	logic pick_video; // Display wins whenever it asks
	logic sel_valid;
	mem_op_e sel_op;
	logic tag_full;
	logic accept; // Memory takes the chosen request
	rd_src_e tag_q [`MEM_MAX_RD];
	logic [$clog2(`MEM_MAX_RD)-1:0] tag_wr, tag_rd;
	rd_count_t tag_cnt;
	logic tag_push;

	assign pick_video = video_bus.valid;
	assign sel_valid = video_bus.valid || cpu_bus.valid;
	assign sel_op = pick_video ? video_bus.opcode : cpu_bus.opcode;
	assign tag_full = (tag_cnt == rd_count_t'(`MEM_MAX_RD));

	// Reads wait while the tag queue is full
	assign mem_read_req = sel_valid && (sel_op == op_read) && !tag_full;
	assign mem_write_req = sel_valid && (sel_op == op_write);
	assign mem_addr = pick_video ? video_bus.addr : cpu_bus.addr;
	assign mem_wdata = pick_video ? video_bus.wdata : cpu_bus.wdata;
	assign mem_be = pick_video ? video_bus.wbe : cpu_bus.wbe;

	assign accept = (mem_read_req || mem_write_req) && mem_ready;

	assign video_bus.stall = video_bus.valid && !accept;
	assign cpu_bus.stall = cpu_bus.valid && !(accept && !pick_video); // Loser stalls too

	// Tag per accepted read, popped as data returns
	assign tag_push = accept && mem_read_req;

	always_ff @(posedge clkrst_mem_clk) begin
		if (reset) begin
			tag_wr <= '0;
			tag_rd <= '0;
			tag_cnt <= '0;
		end else begin
			if (tag_push)
				tag_wr <= tag_wr + 1'b1;
			if (mem_rdata_valid)
				tag_rd <= tag_rd + 1'b1;
			case ({tag_push, mem_rdata_valid})
				2'b10: tag_cnt <= tag_cnt + 1'b1;
				2'b01: tag_cnt <= tag_cnt - 1'b1;
				default: tag_cnt <= tag_cnt;
			endcase
		end
	end

	always_ff @(posedge clkrst_mem_clk) begin
		if (tag_push)
			tag_q[tag_wr] <= pick_video ? src_video : src_cpu;
	end

	assign video_bus.rvalid = mem_rdata_valid && (tag_q[tag_rd] == src_video);
	assign cpu_bus.rvalid = mem_rdata_valid && (tag_q[tag_rd] == src_cpu);
	assign video_bus.rdata = mem_rdata;
	assign cpu_bus.rdata = mem_rdata;

	a_one_req_kind: assert property (@(posedge clkrst_mem_clk) disable iff (reset)
		!(mem_read_req && mem_write_req));

	// Memory returns only what it was asked for
	a_rdata_tagged: assert property (@(posedge clkrst_mem_clk) disable iff (reset)
		mem_rdata_valid |-> tag_cnt != '0);

endmodule

// ==== hw/mem_req_if.sv ====
`timescale 1ns/1ns

interface mem_req_if
	import mem_bus_pkg::*;
();

	logic valid; // Request present
	mem_op_e opcode;
	mem_addr_t addr;
	mem_data_t wdata;
	mem_be_t wbe;
	logic stall; // Request not taken this cycle
	mem_data_t rdata;
	logic rvalid; // One cycle per returned read

	modport requester(
		output valid, opcode, addr, wdata, wbe,
		input stall, rdata, rvalid
	);

	modport responder(
		input valid, opcode, addr, wdata, wbe,
		output stall, rdata, rvalid
	);

endinterface

// ==== hw/mem_subsys.sv ====
`timescale 1ns/1ns
`include "mem_consts.svh"

module mem_subsys
	import mem_bus_pkg::*;
(
	input logic clkrst_mem_clk,
	input logic reset,
	input logic cli0_valid,
	input mem_op_e cli0_opcode,
	input mem_addr_t cli0_addr,
	input mem_data_t cli0_wdata,
	input mem_be_t cli0_wbe,
	output logic cli0_stall,
	output logic cli0_rvalid,
	input logic cli1_valid,
	input mem_op_e cli1_opcode,
	input mem_addr_t cli1_addr,
	input mem_data_t cli1_wdata,
	input mem_be_t cli1_wbe,
	output logic cli1_stall,
	output logic cli1_rvalid,
	input logic cli2_valid,
	input mem_op_e cli2_opcode,
	input mem_addr_t cli2_addr,
	input mem_data_t cli2_wdata,
	input mem_be_t cli2_wbe,
	output logic cli2_stall,
	output logic cli2_rvalid,
	output mem_data_t cli_rdata, // Common to all clients
	input logic video_re,
	input mem_addr_t video_addr,
	output logic video_stall,
	output logic video_rvalid,
	output mem_data_t video_rdata,
	output logic mem_read_req,
	output logic mem_write_req,
	output mem_addr_t mem_addr,
	output mem_data_t mem_wdata,
	output mem_be_t mem_be,
	input logic mem_ready,
	input logic mem_rdata_valid,
	input mem_data_t mem_rdata
);

	mem_op_e [`MEM_CLIENTS-1:0] cli_opcode; // Per element, enums do not concatenate

	assign cli_opcode[0] = cli0_opcode;
	assign cli_opcode[1] = cli1_opcode;
	assign cli_opcode[2] = cli2_opcode;

	mem_req_if cpu_bus();
	mem_req_if video_bus();

	mem_client_arb u_client_arb (
		.clkrst_mem_clk(clkrst_mem_clk),
		.reset(reset),
		.cli_valid({cli2_valid, cli1_valid, cli0_valid}),
		.cli_opcode(cli_opcode),
		.cli_addr({cli2_addr, cli1_addr, cli0_addr}),
		.cli_wdata({cli2_wdata, cli1_wdata, cli0_wdata}),
		.cli_wbe({cli2_wbe, cli1_wbe, cli0_wbe}),
		.cli_stall({cli2_stall, cli1_stall, cli0_stall}),
		.cli_rvalid({cli2_rvalid, cli1_rvalid, cli0_rvalid}),
		.cli_rdata(cli_rdata),
		.cpu_bus(cpu_bus.requester)
	);

	mem_video_port u_video_port (
		.clkrst_mem_clk(clkrst_mem_clk),
		.reset(reset),
		.video_re(video_re),
		.video_addr(video_addr),
		.video_stall(video_stall),
		.video_rvalid(video_rvalid),
		.video_rdata(video_rdata),
		.video_bus(video_bus.requester)
	);

	mem_port_mux u_port_mux (
		.clkrst_mem_clk(clkrst_mem_clk),
		.reset(reset),
		.cpu_bus(cpu_bus.responder),
		.video_bus(video_bus.responder),
		.mem_read_req(mem_read_req),
		.mem_write_req(mem_write_req),
		.mem_addr(mem_addr),
		.mem_wdata(mem_wdata),
		.mem_be(mem_be),
		.mem_ready(mem_ready),
		.mem_rdata_valid(mem_rdata_valid),
		.mem_rdata(mem_rdata)
	);

endmodule

// ==== hw/mem_video_port.sv ====
`timescale 1ns/1ns
`include "mem_consts.svh"

module mem_video_port
	import mem_bus_pkg::*, mem_ctrl_pkg::*;
(
	input logic clkrst_mem_clk,
	input logic reset,
	input logic video_re,
	input mem_addr_t video_addr,
	output logic video_stall,
	output logic video_rvalid,
	output mem_data_t video_rdata,
	mem_req_if.requester video_bus
);

	logic req_valid; // Registered fetch waiting for the mux
	mem_addr_t req_addr;
	rd_count_t out_cnt; // Fetches taken, data not yet back
	logic fetch_take;
	logic bus_take;

	assign fetch_take = video_re && !video_stall;
	assign bus_take = req_valid && !video_bus.stall;

	// Held request, or the in-flight limit reached
	assign video_stall = (req_valid && video_bus.stall) ||
		(out_cnt == rd_count_t'(`MEM_MAX_RD));

	always_ff @(posedge clkrst_mem_clk) begin
		if (reset)
			req_valid <= 1'b0;
		else if (fetch_take)
			req_valid <= 1'b1; // Also refills as the old one leaves
		else if (bus_take)
			req_valid <= 1'b0;
	end

	always_ff @(posedge clkrst_mem_clk) begin
		if (fetch_take)
			req_addr <= video_addr;
	end

	always_ff @(posedge clkrst_mem_clk) begin
		if (reset)
			out_cnt <= '0;
		else if (fetch_take && !video_bus.rvalid)
			out_cnt <= out_cnt + 1'b1;
		else if (video_bus.rvalid && !fetch_take)
			out_cnt <= out_cnt - 1'b1;
	end

	assign video_bus.valid = req_valid;
	assign video_bus.opcode = op_read; // Display only reads
	assign video_bus.addr = req_addr;
	assign video_bus.wdata = '0;
	assign video_bus.wbe = '0;

	assign video_rvalid = video_bus.rvalid;
	assign video_rdata = video_bus.rdata;

	a_cnt_no_underflow: assert property (@(posedge clkrst_mem_clk) disable iff (reset)
		video_bus.rvalid |-> out_cnt != '0);

endmodule

// ==== tb/mem_model.sv ====
`timescale 1ns/1ns
`include "mem_consts.svh"

module mem_model
	import mem_bus_pkg::*;
(
	input logic clk,
	input logic reset,
	input logic read_req,
	input logic write_req,
	input mem_addr_t addr,
	input mem_data_t wdata,
	input mem_be_t be,
	output logic ready,
	output logic rdata_valid,
	output mem_data_t rdata
);

	mem_data_t mem [256]; // Low address bits pick the line
	mem_data_t ret_data [$]; // Reads waiting to return
	longint ret_due [$]; // Edge where each one is sampled
	longint cyc;
	longint last_due;

	initial begin
		for (int i = 0; i < 256; i++)
			mem[i] = {24'hf00d00, 8'(i), ~32'(i)};
		ready = 1'b0;
		rdata_valid = 1'b0;
		rdata = '0;
		cyc = 0;
		last_due = 0;
	end

	always @(posedge clk) begin
		longint due;
		cyc++;
		if (reset) begin
			ret_data.delete();
			ret_due.delete();
			last_due = cyc;
		end else begin
			if (ready && write_req) begin
				for (int b = 0; b < `MEM_DATA_W / 8; b++)
					if (be[b])
						mem[addr[7:0]][8*b +: 8] = wdata[8*b +: 8];
			end
			if (ready && read_req) begin
				due = cyc + 1 + $urandom_range(3); // 1 to 4 cycles
				if (due <= last_due)
					due = last_due + 1; // Keep returns in order
				last_due = due;
				ret_data.push_back(mem[addr[7:0]]);
				ret_due.push_back(due);
			end
		end
		#1;
		ready = !reset && ($urandom_range(3) != 0); // Low about one cycle in four
		rdata_valid = 1'b0;
		if (ret_due.size() > 0 && ret_due[0] == cyc + 1) begin
			rdata_valid = 1'b1;
			rdata = ret_data.pop_front();
			void'(ret_due.pop_front());
		end
	end

endmodule

// ==== tb/tb_clock.sv ====
`timescale 1ns/1ns

module tb_clock (
	output logic clk
);

	initial
		clk = 1'b0;

	always #2 clk = ~clk; // 4 ns period

endmodule

// ==== tb/tb_mem_subsys.sv ====
`timescale 1ns/1ns
`include "mem_consts.svh"

module tb_mem_subsys
	import mem_bus_pkg::*;
();

	localparam int VID = `MEM_CLIENTS; // Source number of the display
	localparam int N_GROUPS = 5;

	typedef struct {
		int grp; // Entries of one group run at the same time
		int src;
		mem_op_e op;
		mem_addr_t addr;
		mem_data_t data;
		mem_be_t be;
	} stim_t;

	logic clk;
	logic reset;
	logic [`MEM_CLIENTS-1:0] cli_valid;
	mem_op_e cli_op [`MEM_CLIENTS];
	mem_addr_t cli_addr [`MEM_CLIENTS];
	mem_data_t cli_wdata [`MEM_CLIENTS];
	mem_be_t cli_wbe [`MEM_CLIENTS];
	logic [`MEM_CLIENTS-1:0] cli_stall;
	logic [`MEM_CLIENTS-1:0] cli_rvalid;
	mem_data_t cli_rdata;
	logic video_re;
	mem_addr_t video_addr;
	logic video_stall;
	logic video_rvalid;
	mem_data_t video_rdata;
	logic mem_read_req;
	logic mem_write_req;
	mem_addr_t mem_addr;
	mem_data_t mem_wdata;
	mem_be_t mem_be;
	logic mem_ready;
	logic mem_rdata_valid;
	mem_data_t mem_rdata;

	stim_t tbl [$];
	logic tbl_ready = 1'b0;
	mem_data_t shadow [256]; // Expected memory contents
	mem_data_t exp_q [VID+1][$]; // Predicted read data per source
	int req_in = 0; // Requests taken at the client and display ports
	int rd_in = 0;
	int mem_acc = 0; // Requests taken at the memory port
	int rv_cnt = 0;

	tb_clock u_clock (.clk(clk));

	mem_subsys u_mem_subsys (
		.clkrst_mem_clk(clk),
		.reset(reset),
		.cli0_valid(cli_valid[0]),
		.cli0_opcode(cli_op[0]),
		.cli0_addr(cli_addr[0]),
		.cli0_wdata(cli_wdata[0]),
		.cli0_wbe(cli_wbe[0]),
		.cli0_stall(cli_stall[0]),
		.cli0_rvalid(cli_rvalid[0]),
		.cli1_valid(cli_valid[1]),
		.cli1_opcode(cli_op[1]),
		.cli1_addr(cli_addr[1]),
		.cli1_wdata(cli_wdata[1]),
		.cli1_wbe(cli_wbe[1]),
		.cli1_stall(cli_stall[1]),
		.cli1_rvalid(cli_rvalid[1]),
		.cli2_valid(cli_valid[2]),
		.cli2_opcode(cli_op[2]),
		.cli2_addr(cli_addr[2]),
		.cli2_wdata(cli_wdata[2]),
		.cli2_wbe(cli_wbe[2]),
		.cli2_stall(cli_stall[2]),
		.cli2_rvalid(cli_rvalid[2]),
		.cli_rdata(cli_rdata),
		.video_re(video_re),
		.video_addr(video_addr),
		.video_stall(video_stall),
		.video_rvalid(video_rvalid),
		.video_rdata(video_rdata),
		.mem_read_req(mem_read_req),
		.mem_write_req(mem_write_req),
		.mem_addr(mem_addr),
		.mem_wdata(mem_wdata),
		.mem_be(mem_be),
		.mem_ready(mem_ready),
		.mem_rdata_valid(mem_rdata_valid),
		.mem_rdata(mem_rdata)
	);

	mem_model u_mem_model (
		.clk(clk),
		.reset(reset),
		.read_req(mem_read_req),
		.write_req(mem_write_req),
		.addr(mem_addr),
		.wdata(mem_wdata),
		.be(mem_be),
		.ready(mem_ready),
		.rdata_valid(mem_rdata_valid),
		.rdata(mem_rdata)
	);

	task automatic stop_on_error(input string line);
		$display("%s", line);
		$display("Finished with errors");
		$fatal(1);
	endtask

	task automatic check_low(input string name, input logic v);
		if (v !== 1'b0)
			stop_on_error($sformatf("FAILED at %0t ns: %s is %b after reset, expected 0",
				$time, name, v));
	endtask

	task automatic check_cli_rdata(input client_idx_t idx, input mem_data_t got);
		mem_data_t exp;
		if (exp_q[idx].size() == 0) begin
			stop_on_error($sformatf("Client %0d returned read data with no read outstanding", idx));
		end else begin
			exp = exp_q[idx].pop_front();
			if (got !== exp)
				stop_on_error($sformatf("FAILED at %0t ns: client %0d read data %h, expected %h",
					$time, idx, got, exp));
		end
	endtask

	task automatic check_video_rdata(input mem_data_t got);
		mem_data_t exp;
		if (exp_q[VID].size() == 0) begin
			stop_on_error("The display port returned data with no fetch outstanding");
		end else begin
			exp = exp_q[VID].pop_front();
			if (got !== exp)
				stop_on_error($sformatf("FAILED at %0t ns: display read data %h, expected %h",
					$time, got, exp));
		end
	endtask

	task automatic add_entry(input int g, input int s, input mem_op_e op, input int a,
		input mem_be_t be);
		stim_t e;
		e.grp = g;
		e.src = s;
		e.op = op;
		e.addr = mem_addr_t'(a);
		e.data = {$urandom, $urandom};
		e.be = be;
		tbl.push_back(e);
	endtask

	task automatic build_table();
		add_entry(0, 0, op_write, 'h10, 8'hff); // Write then read back
		add_entry(0, 0, op_read, 'h10, 8'hff);
		add_entry(1, 1, op_write, 'h20, 8'hff);
		add_entry(1, 1, op_write, 'h20, 8'h5a); // Byte merge
		add_entry(1, 1, op_read, 'h20, 8'hff);
		for (int s = 0; s < `MEM_CLIENTS; s++) begin // All clients at once
			add_entry(2, s, op_write, 'h31 + s, 8'hff);
			add_entry(2, s, op_read, 'h31 + s, 8'hff);
			add_entry(2, s, op_write, 'h10, mem_be_t'(8'h03 << (2 * s))); // Shared line
			add_entry(2, s, op_read, 'h10, 8'hff);
		end
		for (int s = 0; s < `MEM_CLIENTS; s++) begin
			add_entry(3, s, op_write, 'h40 + s, 8'hff);
			add_entry(3, s, op_write, 'h50 + s, 8'hff);
			add_entry(3, s, op_read, 'h40 + s, 8'hff);
		end
		add_entry(3, 0, op_write, 'h53, 8'hff);
		add_entry(3, VID, op_read, 'h10, 8'hff); // Display beside busy clients
		add_entry(3, VID, op_read, 'h20, 8'hff);
		add_entry(3, VID, op_read, 'h31, 8'hff);
		add_entry(3, VID, op_read, 'h32, 8'hff);
		add_entry(3, VID, op_read, 'h33, 8'hff); // More than MEM_MAX_RD in a row
		add_entry(3, VID, op_read, 'h20, 8'hff);
		for (int i = 0; i < 12; i++)
			add_entry(4, $urandom_range(`MEM_CLIENTS - 1),
				$urandom_range(1) ? op_write : op_read,
				'h50 + $urandom_range(3), mem_be_t'($urandom));
		for (int i = 0; i < 4; i++)
			add_entry(4, VID, op_read, (i == 3) ? 'h31 : 'h40 + i, 8'hff);
	endtask

	task automatic drive_src(input int s, input int e);
		if (s == VID) begin
			video_re = (e >= 0);
			if (e >= 0)
				video_addr = tbl[e].addr;
		end else if (e >= 0) begin
			cli_valid[s] = 1'b1;
			cli_op[s] = tbl[e].op;
			cli_addr[s] = tbl[e].addr;
			cli_wdata[s] = tbl[e].data;
			cli_wbe[s] = tbl[e].be;
		end else begin
			cli_valid[s] = 1'b0;
		end
	endtask

	function automatic logic accepted(input int s);
		if (s == VID)
			return video_re && !video_stall;
		return cli_valid[s] && !cli_stall[s];
	endfunction

	// Shadow updated in acceptance order
	task automatic record_accept(input int e);
		int line;
		line = tbl[e].addr[7:0];
		req_in++;
		if (tbl[e].op == op_write) begin
			for (int b = 0; b < `MEM_DATA_W / 8; b++)
				if (tbl[e].be[b])
					shadow[line][8*b +: 8] = tbl[e].data[8*b +: 8];
		end else begin
			exp_q[tbl[e].src].push_back(shadow[line]);
			rd_in++;
		end
	endtask

	function automatic logic all_idle();
		for (int s = 0; s <= VID; s++)
			if (exp_q[s].size() != 0)
				return 1'b0;
		return mem_acc >= req_in; // Writes have reached memory too
	endfunction

	task automatic wait_idle();
		while (!all_idle()) begin
			@(posedge clk);
			#1;
		end
	endtask

	task automatic run_group(input int g);
		int pend [VID+1][$];
		int cur [VID+1];
		logic busy;
		foreach (cur[s])
			cur[s] = -1;
		foreach (tbl[i])
			if (tbl[i].grp == g)
				pend[tbl[i].src].push_back(i);
		wait_idle();
		busy = 1'b1;
		while (busy) begin
			busy = 1'b0;
			for (int s = 0; s <= VID; s++) begin
				if (cur[s] < 0 && pend[s].size() > 0)
					cur[s] = pend[s].pop_front(); // Next entry right after acceptance
				drive_src(s, cur[s]);
				if (cur[s] >= 0)
					busy = 1'b1;
			end
			if (busy) begin
				@(posedge clk);
				for (int s = 0; s <= VID; s++)
					if (cur[s] >= 0 && accepted(s)) begin
						record_accept(cur[s]);
						cur[s] = -1;
					end
				#1;
			end
		end
	endtask

	always @(posedge clk) begin
		if (!reset) begin
			if ((mem_read_req || mem_write_req) && mem_ready)
				mem_acc++;
			for (int k = 0; k < `MEM_CLIENTS; k++)
				if (cli_rvalid[k]) begin
					check_cli_rdata(client_idx_t'(k), cli_rdata);
					rv_cnt++;
				end
			if (video_rvalid) begin
				check_video_rdata(video_rdata);
				rv_cnt++;
			end
		end
	end

	// Watchdog allows 200 cycles per table entry
	initial begin
		wait (tbl_ready);
		repeat (200 * tbl.size() + 10) @(posedge clk);
		stop_on_error("Timeout: the tests did not finish within the allowed number of cycles");
	end

	initial begin
		void'($urandom(32'h3585600a));
		reset = 1'b1;
		cli_valid = '0;
		for (int s = 0; s < `MEM_CLIENTS; s++) begin
			cli_op[s] = op_read;
			cli_addr[s] = '0;
			cli_wdata[s] = '0;
			cli_wbe[s] = '0;
		end
		video_re = 1'b0;
		video_addr = '0;
		build_table();
		tbl_ready = 1'b1;
		repeat (2) @(posedge clk);
		#1;
		reset = 1'b0;
		for (int s = 0; s < `MEM_CLIENTS; s++) begin
			check_low($sformatf("cli%0d_stall", s), cli_stall[s]);
			check_low($sformatf("cli%0d_rvalid", s), cli_rvalid[s]);
		end
		check_low("video_stall", video_stall);
		check_low("video_rvalid", video_rvalid);
		check_low("mem_read_req", mem_read_req);
		check_low("mem_write_req", mem_write_req);
		for (int g = 0; g < N_GROUPS; g++)
			run_group(g);
		wait_idle();
		if (mem_acc == req_in && rv_cnt == rd_in) begin
			$display("Finished with no errors");
			$finish;
		end else begin
			stop_on_error($sformatf(
				"FAILED at %0t ns: %0d of %0d requests at memory, %0d of %0d reads returned",
				$time, mem_acc, req_in, rv_cnt, rd_in));
		end
	end

endmodule
